/* include/riscv_settings.svh */
`ifndef RISCV_SETTINGS_SVH
`define RISCV_SETTINGS_SVH

// Architectural word width fixed by RV32I
`define DATA_WIDTH 32

`define REG_COUNT 32 // Integer registers x0..x31

`define RESET_PC 32'h0000_0000 // First fetch address

`define PROG_WORDS 256 // Instruction memory depth in words

`endif

/* source/riscvPkg.sv */
`include "riscv_settings.svh"

package riscvPkg;

    typedef logic [`DATA_WIDTH-1:0] word_t;
    typedef logic [4:0] regAddr_t;

    typedef enum logic [3:0] {
        aluAdd   = 4'b0000,
        aluSub   = 4'b0001,
        aluSll   = 4'b0010,
        aluSlt   = 4'b0011,
        aluSltu  = 4'b0100,
        aluXor   = 4'b0101,
        aluSrl   = 4'b0110,
        aluSra   = 4'b0111,
        aluOr    = 4'b1000,
        aluAnd   = 4'b1001,
        aluPassB = 4'b1010  // LUI
    } aluCtrl_t;

    typedef enum logic [1:0] {opAdd, opBranch, opFunct, opJump} aluOp_t;

    typedef enum logic [2:0] {
        immI    = 3'b000,
        immS    = 3'b001,
        immB    = 3'b010,
        immU    = 3'b011,
        immJ    = 3'b100,
        immJalr = 3'b101,
        immNone = 3'b111
    } immSrc_t;

    typedef enum logic [1:0] {pcSelPlus4, pcSelJal, pcSelBranch, pcSelJalr} pcSrc_t;

    typedef enum logic [1:0] {resultAlu, resultMem, resultPc4, resultNone} resultSrc_t;

    typedef enum logic [2:0] {
        lsNone  = 3'b000,
        lsWord  = 3'b001,
        lsHalf  = 3'b010,
        lsByte  = 3'b011,
        lsHalfU = 3'b100,
        lsByteU = 3'b101
    } lsMode_t;

endpackage

/* source/ALUDecoder.sv */
`timescale 1ns/1ps

module ALUDecoder (
    input  riscvPkg::aluOp_t   aluOp,
    input  logic               opBit5,
    input  logic [2:0]         funct3,
    input  logic               funct7Bit,
    output riscvPkg::aluCtrl_t aluCtrl
);
    import riscvPkg::*;

    always_comb begin
        case (aluOp)
            opAdd:    aluCtrl = aluAdd; // Address and AUIPC sums
            opBranch: aluCtrl = aluSub; // Compare for zero flag
            opFunct: begin
                case (funct3)
                    3'b000:  aluCtrl = (opBit5 && funct7Bit) ? aluSub : aluAdd; // ADDI has no SUB
                    3'b001:  aluCtrl = aluSll;
                    3'b010:  aluCtrl = aluSlt;
                    3'b011:  aluCtrl = aluSltu;
                    3'b100:  aluCtrl = aluXor;
                    3'b101:  aluCtrl = funct7Bit ? aluSra : aluSrl;
                    3'b110:  aluCtrl = aluOr;
                    default: aluCtrl = aluAnd;
                endcase
            end
            // LUI passes the immediate; JAL ignores the ALU result
            default:  aluCtrl = aluPassB;
        endcase
    end

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
    input  riscvPkg::word_t    a,
    input  riscvPkg::word_t    b,
    input  riscvPkg::aluCtrl_t aluCtrl,
    output riscvPkg::word_t    result,
    output logic               zero,
    output logic               lessSigned,
    output logic               lessUnsigned
);
    import riscvPkg::*;

    assign lessSigned   = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb begin
        case (aluCtrl)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluSll:  result = a << b[4:0];
            aluSlt:  result = word_t'(lessSigned);
            aluSltu: result = word_t'(lessUnsigned);
            aluXor:  result = a ^ b;
            aluSrl:  result = a >> b[4:0];
            aluSra:  result = $signed(a) >>> b[4:0];
            aluOr:   result = a | b;
            aluAnd:  result = a & b;
            default: result = b; // passB
        endcase
    end

    assign zero = (result == '0);

endmodule

/* source/immExtend.sv */
`timescale 1ns/1ps

module immExtend (
    input  riscvPkg::word_t   instr,
    input  riscvPkg::immSrc_t immSrc,
    output riscvPkg::word_t   imm
);
    import riscvPkg::*;

    always_comb begin
        case (immSrc)
            immI, immJalr: imm = {{20{instr[31]}}, instr[31:20]};
            immS:          imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            immU:          imm = {instr[31:12], 12'b0};
            immJ: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default:       imm = '0;
        endcase
    end

endmodule

/* source/registerFile.sv */
`timescale 1ns/1ps
`include "riscv_settings.svh"

module registerFile (
    input  logic               clk,
    input  logic               reset,
    input  riscvPkg::regAddr_t rs1,
    input  riscvPkg::regAddr_t rs2,
    input  riscvPkg::regAddr_t rd,
    input  logic               writeEnable,
    input  riscvPkg::word_t    writeData,
    output riscvPkg::word_t    readData1,
    output riscvPkg::word_t    readData2
);
    import riscvPkg::*;

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (rd != '0)) begin // x0 stays zero
            regs[rd] <= writeData;
        end
    end

    assign readData1 = regs[rs1];
    assign readData2 = regs[rs2];

endmodule

/* source/loadStoreUnit.sv */
`timescale 1ns/1ps

module loadStoreUnit (
    input  logic [1:0]        byteOffset,
    input  riscvPkg::lsMode_t lsMode,
    input  riscvPkg::word_t   storeValue,
    input  riscvPkg::word_t   readData,
    output logic [3:0]        byteEnable,
    output riscvPkg::word_t   writeData,
    output riscvPkg::word_t   loadResult
);
    import riscvPkg::*;

    word_t laneData;

    // Store side replicates the value across lanes
    always_comb begin
        case (lsMode)
            lsWord: begin
                writeData  = storeValue;
                byteEnable = 4'b1111;
            end
            lsHalf, lsHalfU: begin
                writeData  = {2{storeValue[15:0]}};
                byteEnable = byteOffset[1] ? 4'b1100 : 4'b0011;
            end
            lsByte, lsByteU: begin
                writeData  = {4{storeValue[7:0]}};
                byteEnable = 4'b0001 << byteOffset;
            end
            default: begin
                writeData  = '0;
                byteEnable = 4'b0000;
            end
        endcase
    end

    assign laneData = readData >> {byteOffset, 3'b000}; // Addressed lane to bit 0

    always_comb begin
        case (lsMode)
            lsWord:  loadResult = readData;
            lsHalf:  loadResult = {{16{laneData[15]}}, laneData[15:0]};
            lsHalfU: loadResult = {16'b0, laneData[15:0]};
            lsByte:  loadResult = {{24{laneData[7]}}, laneData[7:0]};
            lsByteU: loadResult = {24'b0, laneData[7:0]};
            default: loadResult = '0;
        endcase
    end

endmodule

/* source/pcUnit.sv */
`timescale 1ns/1ps
`include "riscv_settings.svh"

module pcUnit (
    input  logic             clk,
    input  logic             reset,
    input  riscvPkg::pcSrc_t pcSrc,
    input  logic [2:0]       funct3,
    input  logic             zero,
    input  logic             lessSigned,
    input  logic             lessUnsigned,
    input  riscvPkg::word_t  imm,
    input  riscvPkg::word_t  aluResult,
    output riscvPkg::word_t  pc,
    output riscvPkg::word_t  pcPlus4
);
    import riscvPkg::*;

    logic  taken;
    word_t nextPc;

    always_comb begin
        case (funct3)
            3'b000:  taken = zero;          // beq
            3'b001:  taken = !zero;         // bne
            3'b100:  taken = lessSigned;    // blt
            3'b101:  taken = !lessSigned;   // bge
            3'b110:  taken = lessUnsigned;  // bltu
            3'b111:  taken = !lessUnsigned; // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (pcSrc)
            pcSelJal:    nextPc = pc + imm;
            pcSelBranch: nextPc = taken ? pc + imm : pcPlus4;
            pcSelJalr:   nextPc = {aluResult[31:1], 1'b0};
            default:     nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

/* source/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
    input  riscvPkg::word_t      instr,
    output riscvPkg::pcSrc_t     pcSrc,
    output riscvPkg::resultSrc_t resultSrc,
    output logic                 memWrite,
    output riscvPkg::aluCtrl_t   aluCtrl,
    output logic                 aluSrc,
    output riscvPkg::immSrc_t    immSrc,
    output logic                 regWrite,
    output logic                 memRead,
    output riscvPkg::lsMode_t    lsMode
);
    import riscvPkg::*;

    logic [6:0] op;
    logic [2:0] funct3;
    logic       funct7Bit;
    aluOp_t     aluOp;
    logic       isStore;
    logic       isLoad;

    assign op        = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7Bit = instr[30];

    always_comb begin
        regWrite  = 1'b0; // Invalid opcode falls through with no side effects
        immSrc    = immNone;
        aluSrc    = 1'b1;
        memWrite  = 1'b0;
        memRead   = 1'b0;
        resultSrc = resultNone;
        pcSrc     = pcSelPlus4;
        aluOp     = opAdd;
        isStore   = 1'b0;
        isLoad    = 1'b0;

        case (op)
            7'b0110011: begin // R-type
                regWrite  = 1'b1;
                aluSrc    = 1'b0;
                resultSrc = resultAlu;
                aluOp     = opFunct;
            end
            7'b0010011: begin // I-type ALU
                regWrite  = 1'b1;
                immSrc    = immI;
                resultSrc = resultAlu;
                aluOp     = opFunct;
            end
            7'b0000011: begin // Loads
                regWrite  = 1'b1;
                immSrc    = immI;
                resultSrc = resultMem;
                memRead   = 1'b1;
                isLoad    = 1'b1;
            end
            7'b0100011: begin // Stores
                immSrc   = immS;
                memWrite = 1'b1;
                isStore  = 1'b1;
            end
            7'b1100011: begin // Branches
                immSrc = immB;
                aluSrc = 1'b0;
                pcSrc  = pcSelBranch;
                aluOp  = opBranch;
            end
            7'b0110111: begin // LUI
                regWrite  = 1'b1;
                immSrc    = immU;
                resultSrc = resultAlu;
                aluOp     = opJump;
            end
            7'b0010111: begin // AUIPC with srcA from pc
                regWrite  = 1'b1;
                immSrc    = immU;
                resultSrc = resultAlu;
            end
            7'b1101111: begin // JAL
                regWrite  = 1'b1;
                immSrc    = immJ;
                resultSrc = resultPc4;
                pcSrc     = pcSelJal;
                aluOp     = opJump;
            end
            7'b1100111: begin // JALR
                regWrite  = 1'b1;
                immSrc    = immJalr;
                resultSrc = resultPc4;
                pcSrc     = pcSelJalr;
            end
            default: ;
        endcase

        lsMode = lsNone;
        if (isStore) begin
            case (funct3)
                3'b000:  lsMode = lsByte;
                3'b001:  lsMode = lsHalf;
                3'b010:  lsMode = lsWord;
                default: lsMode = lsNone;
            endcase
        end else if (isLoad) begin
            case (funct3)
                3'b000:  lsMode = lsByte;
                3'b001:  lsMode = lsHalf;
                3'b010:  lsMode = lsWord;
                3'b100:  lsMode = lsByteU;
                3'b101:  lsMode = lsHalfU;
                default: lsMode = lsNone;
            endcase
        end

        // Illegal width drops the memory access
        if (lsMode == lsNone) begin
            memWrite = 1'b0;
            memRead  = 1'b0;
        end
    end

    ALUDecoder aluDecoder (
        .aluOp    (aluOp),
        .opBit5   (op[5]),
        .funct3   (funct3),
        .funct7Bit(funct7Bit),
        .aluCtrl  (aluCtrl)
    );

endmodule

/* source/riscvCore.sv */
`timescale 1ns/1ps

module riscvCore (
    input  logic            clk,
    input  logic            reset,
    output riscvPkg::word_t pc,
    input  riscvPkg::word_t instr,
    output riscvPkg::word_t dataAddr,
    output riscvPkg::word_t writeData,
    output logic [3:0]      byteEnable,
    output logic            memWrite,
    output logic            memRead,
    input  riscvPkg::word_t readData
);
    import riscvPkg::*;

    pcSrc_t     pcSrc;
    resultSrc_t resultSrc;
    aluCtrl_t   aluCtrl;
    immSrc_t    immSrc;
    lsMode_t    lsMode;
    logic       aluSrc;
    logic       regWrite;
    logic       memWriteDec;
    word_t      imm;
    word_t      readData1;
    word_t      readData2;
    word_t      srcA;
    word_t      srcB;
    word_t      aluResult;
    logic       zero;
    logic       lessSigned;
    logic       lessUnsigned;
    word_t      loadResult;
    word_t      pcPlus4;
    word_t      result;

    controlUnit control (
        .instr    (instr),
        .pcSrc    (pcSrc),
        .resultSrc(resultSrc),
        .memWrite (memWriteDec),
        .aluCtrl  (aluCtrl),
        .aluSrc   (aluSrc),
        .immSrc   (immSrc),
        .regWrite (regWrite),
        .memRead  (memRead),
        .lsMode   (lsMode)
    );

    immExtend immGen (
        .instr (instr),
        .immSrc(immSrc),
        .imm   (imm)
    );

    registerFile regFile (
        .clk        (clk),
        .reset      (reset),
        .rs1        (instr[19:15]),
        .rs2        (instr[24:20]),
        .rd         (instr[11:7]),
        .writeEnable(regWrite),
        .writeData  (result),
        .readData1  (readData1),
        .readData2  (readData2)
    );

    assign srcA = (instr[6:0] == 7'b0010111) ? pc : readData1; // AUIPC adds to pc
    assign srcB = aluSrc ? imm : readData2;

    alu alu (
        .a           (srcA),
        .b           (srcB),
        .aluCtrl     (aluCtrl),
        .result      (aluResult),
        .zero        (zero),
        .lessSigned  (lessSigned),
        .lessUnsigned(lessUnsigned)
    );

    loadStoreUnit lsu (
        .byteOffset(aluResult[1:0]),
        .lsMode    (lsMode),
        .storeValue(readData2),
        .readData  (readData),
        .byteEnable(byteEnable),
        .writeData (writeData),
        .loadResult(loadResult)
    );

    pcUnit pcGen (
        .clk         (clk),
        .reset       (reset),
        .pcSrc       (pcSrc),
        .funct3      (instr[14:12]),
        .zero        (zero),
        .lessSigned  (lessSigned),
        .lessUnsigned(lessUnsigned),
        .imm         (imm),
        .aluResult   (aluResult),
        .pc          (pc),
        .pcPlus4     (pcPlus4)
    );

    assign dataAddr = {aluResult[31:2], 2'b00};
    assign memWrite = memWriteDec && !reset; // No stores while in reset

    always_comb begin
        case (resultSrc)
            resultAlu: result = aluResult;
            resultMem: result = loadResult;
            resultPc4: result = pcPlus4;
            default:   result = '0;
        endcase
    end

endmodule

/* verification/riscvCoreTb.sv */
`timescale 1ns/1ps
`include "riscv_settings.svh"

module riscvCoreTb;
    import riscvPkg::*;

    localparam int IMEM_BITS = $clog2(`PROG_WORDS);
    localparam int DATA_WORDS = 128;          // Aliased window on 0x1000..0x11FF
    localparam int DUMP_INDEX = 64;           // Register dump at 0x1100
    localparam int BODY_END = `PROG_WORDS - 33;
    localparam int CYCLE_LIMIT = `PROG_WORDS * 4;
    localparam word_t LOOP_PC = (`PROG_WORDS - 1) * 4;
    localparam word_t RESET_STORE = 32'h0000_2023; // sw x0, 0(x0)

    logic       clk;
    logic       reset;
    word_t      pc;
    word_t      instr;
    word_t      dataAddr;
    word_t      writeData;
    logic [3:0] byteEnable;
    logic       memWrite;
    logic       memRead;
    word_t      readData;

    word_t  imem [`PROG_WORDS];
    word_t  dmem [DATA_WORDS];
    word_t  modelMem [DATA_WORDS];
    word_t  modelRegs [`REG_COUNT];
    word_t  modelPc;
    logic   expStore;
    logic   expLoad;
    word_t  expAddr;
    logic [3:0] expEnable;
    word_t  expData;
    integer seed = 32'h11cd;
    int     wordErrors;
    int     enableErrors;
    int     controlErrors;
    int     cycles;
    int     settle;
    bit     hung;

    riscvCore DUT (
        .clk       (clk),
        .reset     (reset),
        .pc        (pc),
        .instr     (instr),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .byteEnable(byteEnable),
        .memWrite  (memWrite),
        .memRead   (memRead),
        .readData  (readData)
    );

    // A store is presented while in reset
    assign instr    = reset ? RESET_STORE : imem[pc[IMEM_BITS+1:2]];
    assign readData = dmem[dataAddr[8:2]];

    always @(posedge clk) begin
        if (memWrite) begin
            for (int k = 0; k < 4; k++) begin
                if (byteEnable[k]) begin
                    dmem[dataAddr[8:2]][8*k +: 8] <= writeData[8*k +: 8];
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int pick(input int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic word_t encS(input logic [11:0] imm, input regAddr_t rs2,
                                   input regAddr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t encB(input logic [12:0] imm, input regAddr_t rs2,
                                   input regAddr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t encJ(input logic [20:0] imm, input regAddr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic buildProgram();
        int         idx;
        int         kind;
        int         k;
        regAddr_t   rd;
        regAddr_t   rs1;
        regAddr_t   rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [6:0] op;
        logic [11:0] imm;
        bit         jumpTarget [`PROG_WORDS];

        idx = 0;
        for (int r = 1; r < 32; r++) begin // Nonzero constants with x30 as data base
            if (r == 30) begin
                imem[idx++] = {20'h00001, 5'd30, 7'b0110111};
            end else begin
                imem[idx++] = {20'(pick(1 << 20)), 5'(r), 7'b0110111};
                imem[idx++] = {12'(pick(4096)), 5'(r), 3'b000, 5'(r), 7'b0010011};
            end
        end
        while (idx < BODY_END) begin
            kind = pick(10);
            rd   = 5'(pick(30));
            rs1  = 5'(pick(32));
            rs2  = 5'(pick(32));
            if (kind == 7 && (idx + 2 > BODY_END || jumpTarget[idx + 1])) begin
                kind = 0; // No room or jalr entered without its auipc
            end
            case (kind)
                1: begin
                    f3  = 3'(pick(8));
                    imm = 12'(pick(4096));
                    if (f3 == 3'd1) imm = {7'b0, imm[4:0]};
                    if (f3 == 3'd5) imm = {1'b0, pick(2) != 0, 5'b0, imm[4:0]};
                    imem[idx++] = {imm, rs1, f3, rd, 7'b0010011};
                end
                2: begin
                    op = pick(2) != 0 ? 7'b0110111 : 7'b0010111;
                    imem[idx++] = {20'(pick(1 << 20)), rd, op};
                end
                3: begin
                    k   = pick(5);
                    f3  = (k == 3) ? 3'd4 : (k == 4) ? 3'd5 : 3'(k);
                    imm = 12'(pick(256 >> f3[1:0]) << f3[1:0]);
                    imem[idx++] = {imm, 5'd30, f3, rd, 7'b0000011};
                end
                4: begin
                    f3  = 3'(pick(3));
                    imm = 12'(pick(256 >> f3[1:0]) << f3[1:0]);
                    imem[idx++] = encS(imm, rs2, 5'd30, f3);
                end
                5: begin
                    f3 = 3'(pick(6));
                    if (f3 >= 3'd2) f3 = f3 + 3'd2; // Skip the two reserved codes
                    if (pick(2) != 0) rs2 = rs1;
                    k = pick(4);
                    if (idx + 1 + k > BODY_END) k = BODY_END - idx - 1;
                    jumpTarget[idx + 1 + k] = 1'b1;
                    imem[idx++] = encB(13'(4 * (k + 1)), rs2, rs1, f3);
                end
                6: begin
                    k = pick(4);
                    if (idx + 1 + k > BODY_END) k = BODY_END - idx - 1;
                    jumpTarget[idx + 1 + k] = 1'b1;
                    imem[idx++] = encJ(21'(4 * (k + 1)), rd);
                end
                7: begin
                    k = pick(3);
                    if (idx + 2 + k > BODY_END) k = BODY_END - idx - 2;
                    jumpTarget[idx + 2 + k] = 1'b1;
                    imem[idx++] = {20'b0, 5'd31, 7'b0010111};
                    // Odd offset so bit 0 must be dropped
                    imem[idx++] = {12'(9 + 4 * k), 5'd31, 3'b000, rd, 7'b1100111};
                end
                8: begin
                    case (pick(4))
                        0:       op = 7'b0001011;
                        1:       op = 7'b0101011;
                        2:       op = 7'b1011011;
                        default: op = 7'b1111011;
                    endcase
                    imem[idx++] = {25'($random(seed)), op};
                end
                default: begin // R-type
                    f3 = 3'(pick(8));
                    f7 = ((f3 == 3'd0 || f3 == 3'd5) && pick(2) != 0) ? 7'b0100000 : 7'b0;
                    imem[idx++] = {f7, rs2, rs1, f3, rd, 7'b0110011};
                end
            endcase
        end
        for (int r = 0; r < 32; r++) begin
            imem[idx++] = encS(12'(256 + 4 * r), 5'(r), 5'd30, 3'b010);
        end
        imem[idx] = encJ(21'd0, 5'd0); // Self-loop
    endtask

    // RV32I reference step that also records the expected store
    task automatic stepModel(input word_t ins);
        logic [6:0] op;
        logic [2:0] f3;
        regAddr_t   rd;
        word_t      a;
        word_t      b;
        word_t      immI;
        word_t      immS;
        word_t      immB;
        word_t      immU;
        word_t      immJ;
        word_t      res;
        word_t      addr;
        word_t      lane;
        word_t      nextPc;
        logic       wr;
        logic       take;
        int         off;
        int         size;

        op   = ins[6:0];
        f3   = ins[14:12];
        rd   = ins[11:7];
        a    = modelRegs[ins[19:15]];
        b    = modelRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immU = {ins[31:12], 12'b0};
        immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nextPc   = modelPc + 4;
        wr       = 1'b0;
        res      = '0;
        expStore = 1'b0;
        expLoad  = 1'b0;
        case (op)
            7'b0110011: begin
                wr  = 1'b1;
                res = aluModel(f3, ins[30], a, b, 1'b1);
            end
            7'b0010011: begin
                wr  = 1'b1;
                res = aluModel(f3, ins[30], a, immI, 1'b0);
            end
            7'b0000011: begin
                wr      = 1'b1;
                expLoad = 1'b1;
                addr    = a + immI;
                lane    = modelMem[addr[8:2]] >> (8 * addr[1:0]);
                case (f3)
                    3'b000:  res = {{24{lane[7]}}, lane[7:0]};
                    3'b001:  res = {{16{lane[15]}}, lane[15:0]};
                    3'b010:  res = lane;
                    3'b100:  res = {24'b0, lane[7:0]};
                    default: res = {16'b0, lane[15:0]};
                endcase
            end
            7'b0100011: begin
                addr     = a + immS;
                off      = addr[1:0];
                size     = 1 << f3[1:0]; // Bytes written
                expStore = 1'b1;
                expAddr  = addr & ~32'd3;
                for (int k = 0; k < 4; k++) begin
                    expEnable[k]      = (k >= off) && (k < off + size);
                    expData[8*k +: 8] = b[8*(k % size) +: 8];
                    if (expEnable[k]) modelMem[addr[8:2]][8*k +: 8] = expData[8*k +: 8];
                end
            end
            7'b1100011: begin
                case (f3)
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    3'b110:  take = (a < b);
                    default: take = (a >= b);
                endcase
                if (take) nextPc = modelPc + immB;
            end
            7'b0110111: begin
                wr  = 1'b1;
                res = immU;
            end
            7'b0010111: begin
                wr  = 1'b1;
                res = modelPc + immU;
            end
            7'b1101111: begin
                wr     = 1'b1;
                res    = modelPc + 4;
                nextPc = modelPc + immJ;
            end
            7'b1100111: begin
                wr     = 1'b1;
                res    = modelPc + 4;
                nextPc = (a + immI) & ~32'd1;
            end
            default: ; // Unknown opcode does nothing
        endcase
        if (wr && rd != 5'd0) modelRegs[rd] = res;
        modelPc = nextPc;
    endtask

    function automatic word_t aluModel(input logic [2:0] f3, input logic alt, input word_t x,
                                       input word_t y, input logic regForm);
        word_t r;

        case (f3)
            3'b000:  r = (regForm && alt) ? x - y : x + y;
            3'b001:  r = x << y[4:0];
            3'b010:  r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011:  r = (x < y) ? 32'd1 : 32'd0;
            3'b100:  r = x ^ y;
            3'b101: begin
                if (alt) r = word_t'($signed(x) >>> y[4:0]);
                else r = x >> y[4:0];
            end
            3'b110:  r = x | y;
            default: r = x & y;
        endcase
        return r;
    endfunction

    task automatic compareWord(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            wordErrors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compareEnable(input string name, input logic [3:0] expected,
                                 input logic [3:0] actual);
        if (actual !== expected) begin
            enableErrors++;
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic compareBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            controlErrors++;
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic checkCycle();
        compareWord($sformatf("pc cycle %0d", cycles), modelPc, pc);
        stepModel(imem[modelPc[IMEM_BITS+1:2]]);
        compareBit($sformatf("memWrite cycle %0d", cycles), expStore, memWrite);
        compareBit($sformatf("memRead cycle %0d", cycles), expLoad, memRead);
        if (expStore && memWrite) begin
            compareWord($sformatf("dataAddr cycle %0d", cycles), expAddr, dataAddr);
            compareEnable($sformatf("byteEnable cycle %0d", cycles), expEnable, byteEnable);
            compareWord($sformatf("writeData cycle %0d", cycles), expData, writeData);
        end
    endtask

    initial begin
        reset = 1'b1;
        buildProgram();
        for (int i = 0; i < DATA_WORDS; i++) begin
            dmem[i]     = (32'h9e37_79b9 * (i + 1)) ^ (i << 16);
            modelMem[i] = (32'h9e37_79b9 * (i + 1)) ^ (i << 16);
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        modelPc = `RESET_PC;
        repeat (5) begin
            @(negedge clk);
            compareWord("pc during reset", `RESET_PC, pc);
            compareBit("memWrite during reset", 1'b0, memWrite);
        end
        reset = 1'b0;
        while (!hung && settle < 3) begin
            checkCycle();
            if (pc == LOOP_PC) settle++;
            cycles++;
            if (cycles >= CYCLE_LIMIT) hung = 1'b1;
            @(negedge clk);
        end
        if (hung) begin
            controlErrors++;
            $display("Core hangs: final loop not reached within %0d cycles", CYCLE_LIMIT);
        end
        for (int r = 0; r < 32; r++) begin
            compareWord($sformatf("dump x%0d", r), modelRegs[r], dmem[DUMP_INDEX + r]);
        end
        compareWord("x0 reads zero", 32'd0, dmem[DUMP_INDEX]);
        $display("Errors: word %0d, enable %0d, control %0d",
                 wordErrors, enableErrors, controlErrors);
        if (wordErrors + enableErrors + controlErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+include
source/riscvPkg.sv
source/ALUDecoder.sv
source/alu.sv
source/immExtend.sv
source/registerFile.sv
source/loadStoreUnit.sv
source/pcUnit.sv
source/controlUnit.sv
source/riscvCore.sv
verification/riscvCoreTb.sv
